/* include/video_reconf_params.svh */
`ifndef VIDEO_RECONF_PARAMS_SVH
`define VIDEO_RECONF_PARAMS_SVH

// scan chain geometry
`define SCAN_LEN        144
`define SCAN_ADDR_W     8

// host credits start at this value
`define CMD_QUEUE_DEPTH 4

// pixel pll scan-chain images, bit a goes out at address a
`define PLL_BITS_1080P \
    144'h0C01_8060_2008_0401_0040_1006_0080_0C02_0301
`define PLL_BITS_960P \
    144'h0C01_8060_2008_0601_0050_1004_0180_0A02_0281
`define PLL_BITS_480P \
    144'h0801_C060_300C_0401_0060_1806_0040_0E02_0205
`define PLL_BITS_VGA \
    144'h0801_C070_300C_0501_0064_1806_00C0_0E03_0207
`define PLL_BITS_240P_1080P \
    144'h0C01_8060_2008_0401_8040_1006_0080_0C02_8301

`endif

/* design/video_reconf_pkg.sv */
package video_reconf_pkg;

    // mode code carried in the low nibble of a host command
    typedef enum logic [3:0] {
        mode_1080p      = 4'h0,
        mode_960p       = 4'h1,
        mode_480p       = 4'h2,
        mode_vga        = 4'h3,
        mode_240p_1080p = 4'h8,
        mode_240p_960p  = 4'h9,
        mode_240p_480p  = 4'hA,
        mode_240p_vga   = 4'hB
    } video_mode_e;

    // one byte from the host, mode kept raw since invalid codes must pass through
    typedef struct packed {
        logic       force_vga;  // bit 7
        logic [2:0] reserved;
        logic [3:0] mode;
    } mode_cmd_t;

    // active video configuration
    typedef struct packed {
        video_mode_e mode;
        logic        force_vga;
    } video_config_t;

    // reconfiguration controller states
    typedef enum logic [2:0] {
        idle,       // grant a pop
        pop,        // waiting for the rom to load or drop
        stream,     // shifting the scan chain out
        settle,     // waiting for the reconfigure pulse
        wait_busy   // pll still reconfiguring
    } reconf_state_e;

endpackage

/* design/mode_cmd_queue.sv */
`timescale 1ns/1ns
`include "video_reconf_params.svh"

module mode_cmd_queue (
    input  logic                        clock,
    input  logic                        rst_n,
    input  video_reconf_pkg::mode_cmd_t cmd,
    input  logic                        cmd_valid,
    input  logic                        rd_req,
    output video_reconf_pkg::mode_cmd_t head,
    output logic                        empty,
    output logic                        credit_return
);

    localparam int DEPTH = `CMD_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    video_reconf_pkg::mode_cmd_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop_entry;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push      = cmd_valid;           // host only sends with a credit in hand
    assign pop_entry = rd_req && !empty;
    assign empty     = (count == '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop_entry;     // one credit back per freed slot
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_entry) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop_entry})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/reconf_rom.sv */
`timescale 1ns/1ns
`include "video_reconf_params.svh"

module reconf_rom (
    input  logic                            clock,
    input  logic                            rst_n,
    input  video_reconf_pkg::mode_cmd_t     head,
    input  logic                            empty,
    input  logic                            pop_ena,
    output logic                            rd_req,
    output logic                            loaded,
    output logic                            dropped,
    input  logic                            read_ena,
    input  logic [`SCAN_ADDR_W-1:0]         address,
    output logic                            scan_data,
    output logic                            reconfig,
    output video_reconf_pkg::video_config_t video_config
);

    video_reconf_pkg::mode_cmd_t cmd_q;
    logic                        cmd_vld;   // cmd_q holds a freshly popped command
    logic                        grant_q;   // pop granted, queue was empty
    logic                        start_pop;
    logic                        mode_ok;
    logic [`SCAN_LEN-1:0]        stream_bits;
    logic                        bit_q;
    logic                        read_ena_d;
    logic                        fall_q;
    logic                        fall_d1;

    function automatic logic valid_mode(input logic [3:0] code);
        case (code)
            video_reconf_pkg::mode_1080p,
            video_reconf_pkg::mode_960p,
            video_reconf_pkg::mode_480p,
            video_reconf_pkg::mode_vga,
            video_reconf_pkg::mode_240p_1080p,
            video_reconf_pkg::mode_240p_960p,
            video_reconf_pkg::mode_240p_480p,
            video_reconf_pkg::mode_240p_vga: return 1'b1;
            default:                         return 1'b0;
        endcase
    endfunction

    assign start_pop = (pop_ena || grant_q) && !empty;
    assign mode_ok   = valid_mode(cmd_q.mode);

    // 240p modes other than 1080p share the progressive pll settings
    always_comb begin
        case (video_config.mode)
            video_reconf_pkg::mode_960p,
            video_reconf_pkg::mode_240p_960p:  stream_bits = `PLL_BITS_960P;
            video_reconf_pkg::mode_480p,
            video_reconf_pkg::mode_240p_480p:  stream_bits = `PLL_BITS_480P;
            video_reconf_pkg::mode_vga,
            video_reconf_pkg::mode_240p_vga:   stream_bits = `PLL_BITS_VGA;
            video_reconf_pkg::mode_240p_1080p: stream_bits = `PLL_BITS_240P_1080P;
            default:                           stream_bits = `PLL_BITS_1080P;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rd_req) begin
            cmd_q <= head;  // queue pops on this same cycle
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            grant_q      <= 1'b0;
            rd_req       <= 1'b0;
            cmd_vld      <= 1'b0;
            loaded       <= 1'b0;
            dropped      <= 1'b0;
            video_config <= '{mode: video_reconf_pkg::mode_1080p, force_vga: 1'b0};
        end else begin
            rd_req <= start_pop;
            if (start_pop) begin
                grant_q <= 1'b0;
            end else if (pop_ena) begin
                grant_q <= 1'b1;    // hold the grant until something arrives
            end
            cmd_vld <= rd_req;
            loaded  <= cmd_vld && mode_ok;
            dropped <= cmd_vld && !mode_ok;
            if (cmd_vld && mode_ok) begin
                video_config.mode      <= video_reconf_pkg::video_mode_e'(cmd_q.mode);
                video_config.force_vga <= cmd_q.force_vga;
            end
        end
    end

    // two register stages, same latency as a block rom with registered output
    always_ff @(posedge clock) begin
        bit_q     <= stream_bits[address];
        scan_data <= bit_q;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_ena_d <= 1'b0;
            fall_q     <= 1'b0;
            fall_d1    <= 1'b0;
            reconfig   <= 1'b0;
        end else begin
            read_ena_d <= read_ena;
            fall_q     <= read_ena_d && !read_ena;  // end of stream
            fall_d1    <= fall_q;
            reconfig   <= fall_d1;                  // lines up behind the last scan bit
        end
    end

endmodule

/* design/pll_reconfig_ctrl.sv */
`timescale 1ns/1ns
`include "video_reconf_params.svh"

module pll_reconfig_ctrl (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    loaded,
    input  logic                    dropped,
    input  logic                    reconfig,
    input  logic                    pll_busy,
    output logic                    pop_ena,
    output logic                    read_ena,
    output logic [`SCAN_ADDR_W-1:0] address,
    output logic                    scan_ena
);

    localparam logic [`SCAN_ADDR_W-1:0] LAST_ADDR = `SCAN_ADDR_W'(`SCAN_LEN - 1);

    video_reconf_pkg::reconf_state_e state;
    logic                            scan_ena_d;

    assign pop_ena  = (state == video_reconf_pkg::idle);
    assign read_ena = (state == video_reconf_pkg::stream);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= video_reconf_pkg::idle;
            address    <= '0;
            scan_ena_d <= 1'b0;
            scan_ena   <= 1'b0;
        end else begin
            // matches the two-stage data path in the rom
            scan_ena_d <= read_ena;
            scan_ena   <= scan_ena_d;

            case (state)
                video_reconf_pkg::idle: begin
                    state <= video_reconf_pkg::pop;     // grant lasts one cycle
                end

                video_reconf_pkg::pop: begin
                    if (loaded) begin
                        state   <= video_reconf_pkg::stream;
                        address <= '0;
                    end else if (dropped) begin
                        state <= video_reconf_pkg::idle;  // bad code, try the next one
                    end
                end

                video_reconf_pkg::stream: begin
                    if (address == LAST_ADDR) begin
                        state   <= video_reconf_pkg::settle;
                        address <= '0;
                    end else begin
                        address <= address + 1'b1;
                    end
                end

                video_reconf_pkg::settle: begin
                    if (reconfig) begin
                        state <= video_reconf_pkg::wait_busy;
                    end
                end

                video_reconf_pkg::wait_busy: begin
                    // pll_busy held high keeps later commands in the queue
                    if (!pll_busy) begin
                        state <= video_reconf_pkg::idle;
                    end
                end

                default: begin
                    state <= video_reconf_pkg::idle;
                end
            endcase
        end
    end

endmodule

/* design/video_reconf_top.sv */
`timescale 1ns/1ns
`include "video_reconf_params.svh"

module video_reconf_top (
    input  logic                            clock,
    input  logic                            rst_n,
    input  video_reconf_pkg::mode_cmd_t     cmd,
    input  logic                            cmd_valid,
    output logic                            credit_return,
    input  logic                            pll_busy,
    output logic                            scan_data,
    output logic                            scan_ena,
    output logic                            reconfig,
    output video_reconf_pkg::video_config_t video_config
);

    video_reconf_pkg::mode_cmd_t head;
    logic                        empty;
    logic                        rd_req;
    logic                        pop_ena;
    logic                        loaded;
    logic                        dropped;
    logic                        read_ena;
    logic [`SCAN_ADDR_W-1:0]     address;

    mode_cmd_queue u_queue (
        .clock(clock), .rst_n(rst_n),
        .cmd(cmd), .cmd_valid(cmd_valid), .rd_req(rd_req),
        .head(head), .empty(empty), .credit_return(credit_return)
    );

    reconf_rom u_rom (
        .clock(clock), .rst_n(rst_n),
        .head(head), .empty(empty), .pop_ena(pop_ena),
        .rd_req(rd_req), .loaded(loaded), .dropped(dropped),
        .read_ena(read_ena), .address(address),
        .scan_data(scan_data), .reconfig(reconfig), .video_config(video_config)
    );

    pll_reconfig_ctrl u_ctrl (
        .clock(clock), .rst_n(rst_n),
        .loaded(loaded), .dropped(dropped), .reconfig(reconfig), .pll_busy(pll_busy),
        .pop_ena(pop_ena), .read_ena(read_ena), .address(address), .scan_ena(scan_ena)
    );

endmodule

/* tb/tb_video_reconf.sv */
`timescale 1ns/1ns
`include "video_reconf_params.svh"

module tb_video_reconf;

    localparam int SCAN_LEN    = `SCAN_LEN;
    localparam int DEPTH       = `CMD_QUEUE_DEPTH;
    localparam int TOTAL_CMDS  = 26;
    localparam int CYCLE_LIMIT = 8 * (TOTAL_CMDS * (SCAN_LEN + 20)) + 2000;

    logic                            clock;
    logic                            rst_n;
    video_reconf_pkg::mode_cmd_t     cmd;
    logic                            cmd_valid;
    logic                            credit_return;
    logic                            pll_busy;
    logic                            scan_data;
    logic                            scan_ena;
    logic                            reconfig;
    video_reconf_pkg::video_config_t video_config;

    video_reconf_pkg::mode_cmd_t     exp_q[$];    // valid commands still to stream
    video_reconf_pkg::video_config_t exp_config;
    logic [SCAN_LEN-1:0]             got_bits;
    logic                            scan_ena_q;
    logic                            scan_end_q;  // scan_ena fell on the previous cycle
    logic                            reconfig_q;
    int                              bit_count;
    int                              credits;
    int                              stream_count;
    int                              reconfig_count;
    int                              sent_count;
    int                              errors;
    int                              cycle_count;
    integer                          seed;

    video_reconf_top uut (
        .clock(clock), .rst_n(rst_n),
        .cmd(cmd), .cmd_valid(cmd_valid), .credit_return(credit_return),
        .pll_busy(pll_busy), .scan_data(scan_data), .scan_ena(scan_ena),
        .reconfig(reconfig), .video_config(video_config)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic valid_code(input logic [3:0] code);
        return (code <= 4'd3) || (code >= 4'd8 && code <= 4'd11);
    endfunction

    // 240p codes other than 8 reuse the progressive images
    function automatic logic [SCAN_LEN-1:0] bitstream_for(input logic [3:0] code);
        case (code)
            4'd0:       return `PLL_BITS_1080P;
            4'd1, 4'd9:  return `PLL_BITS_960P;
            4'd2, 4'd10: return `PLL_BITS_480P;
            4'd3, 4'd11: return `PLL_BITS_VGA;
            4'd8:       return `PLL_BITS_240P_1080P;
            default:    return '0;
        endcase
    endfunction

    function automatic logic [3:0] code_from_index(input int idx);
        case (idx)
            0, 1, 2, 3: return 4'(idx);
            4, 5, 6, 7: return 4'(idx + 4);   // codes 8 to 11
            8:          return 4'd4;
            9:          return 4'd7;
            10:         return 4'd12;
            default:    return 4'd15;
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_stream();
        video_reconf_pkg::mode_cmd_t     c;
        video_reconf_pkg::video_config_t cfg;
        logic [SCAN_LEN-1:0]             expected;
        check_equal("scan_ena length", bit_count, SCAN_LEN);
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("a scan stream ran with no valid command pending");
        end
        if (exp_q.size() > 0) begin
            c = exp_q.pop_front();
            expected = bitstream_for(c.mode);
            cfg.mode = video_reconf_pkg::video_mode_e'(c.mode);
            cfg.force_vga = c.force_vga;
            assert (got_bits === expected) else begin
                errors++;
                $display("Mismatch scan_data: got %h expected %h", got_bits, expected);
            end
            check_equal("video_config", video_config, cfg);
        end
        stream_count++;
    endtask

    // registered outputs are sampled on the falling edge
    always @(negedge clock) begin
        if (rst_n) begin
            if (credit_return) begin
                credits++;
            end
            if (reconfig) begin
                reconfig_count++;
                assert (!reconfig_q) else begin
                    errors++;
                    $display("reconfig stayed high for more than one cycle");
                end
                assert (scan_end_q) else begin
                    errors++;
                    $display("reconfig did not come one cycle after scan_ena fell");
                end
            end
            if (scan_ena) begin
                if (bit_count < SCAN_LEN) begin
                    got_bits[bit_count] = scan_data;
                end
                bit_count++;
            end else if (scan_ena_q) begin
                finish_stream();
                bit_count = 0;
            end
            scan_end_q = scan_ena_q && !scan_ena;
            scan_ena_q = scan_ena;
            reconfig_q = reconfig;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("summary: %0d errors, %0d streams, %0d commands", errors + 1,
                     stream_count, sent_count);
            $display("Errors found");
            $finish;
        end
    end

    task automatic send_cmd(input logic [3:0] code, input logic fv);
        video_reconf_pkg::mode_cmd_t c;
        @(posedge clock);
        while (credits == 0) begin
            @(posedge clock);
        end
        c.force_vga = fv;
        c.reserved  = '0;
        c.mode      = code;
        cmd       <= c;
        cmd_valid <= 1'b1;
        credits--;
        sent_count++;
        if (valid_code(code)) begin
            exp_q.push_back(c);
            exp_config.mode      = video_reconf_pkg::video_mode_e'(code);
            exp_config.force_vga = fv;
        end
        @(posedge clock);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clock);
        while (!(exp_q.size() == 0 && credits == DEPTH && !scan_ena &&
                 reconfig_count == stream_count)) begin
            @(negedge clock);
        end
        repeat (8) @(negedge clock);
    endtask

    task automatic check_reset_state();
        repeat (6) begin
            @(negedge clock);
            check_equal("reconfig", reconfig, 1'b0);
            check_equal("scan_ena", scan_ena, 1'b0);
            check_equal("credit_return", credit_return, 1'b0);
            check_equal("video_config", video_config, exp_config);
        end
    endtask

    task automatic run_single(input logic [3:0] code, input logic fv);
        int streams_before;
        int pulses_before;
        streams_before = stream_count;
        pulses_before  = reconfig_count;
        send_cmd(code, fv);
        wait_done();
        check_equal("stream count", stream_count - streams_before, valid_code(code));
        check_equal("reconfig pulses", reconfig_count - pulses_before, valid_code(code));
        check_equal("credits", credits, DEPTH);
        check_equal("video_config", video_config, exp_config);
    endtask

    task automatic test_back_pressure();
        int streams_before;
        streams_before = stream_count;
        @(posedge clock);
        pll_busy <= 1'b1;
        send_cmd(4'd3, 1'b0);
        send_cmd(4'd0, 1'b1);
        send_cmd(4'd9, 1'b0);
        send_cmd(4'd2, 1'b1);
        repeat (2 * (SCAN_LEN + 20)) @(negedge clock);
        assert (stream_count - streams_before <= 1) else begin
            errors++;
            $display("more than one stream ran while pll_busy was high");
        end
        check_equal("credits while busy", credits, 1);
        @(posedge clock);
        pll_busy <= 1'b0;
        wait_done();
        check_equal("stream count", stream_count - streams_before, DEPTH);
        check_equal("credits", credits, DEPTH);
        check_equal("video_config", video_config, exp_config);
    endtask

    task automatic test_random();
        int r;
        int stretch;
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            send_cmd(code_from_index($unsigned(r) % 12), r[8]);
            stretch = $unsigned($random(seed)) % 320;
            if (stretch > 120) begin    // long holds reach past the end of a stream
                @(posedge clock);
                pll_busy <= 1'b1;
                repeat (stretch) @(posedge clock);
                pll_busy <= 1'b0;
            end
        end
        wait_done();
        check_equal("credits", credits, DEPTH);
        check_equal("video_config", video_config, exp_config);
    endtask

    initial begin
        rst_n          = 1'b0;
        cmd            = '0;
        cmd_valid      = 1'b0;
        pll_busy       = 1'b0;
        seed           = 32'haf70;
        credits        = DEPTH;
        bit_count      = 0;
        stream_count   = 0;
        reconfig_count = 0;
        sent_count     = 0;
        errors         = 0;
        cycle_count    = 0;
        scan_ena_q     = 1'b0;
        scan_end_q     = 1'b0;
        reconfig_q     = 1'b0;
        got_bits       = '0;
        exp_config     = '{mode: video_reconf_pkg::mode_1080p, force_vga: 1'b0};

        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        check_reset_state();

        run_single(4'd0, 1'b0);
        run_single(4'd1, 1'b0);
        run_single(4'd2, 1'b0);
        run_single(4'd3, 1'b0);
        run_single(4'd8, 1'b0);
        run_single(4'd9, 1'b1);
        run_single(4'd10, 1'b0);
        run_single(4'd11, 1'b1);
        run_single(4'd4, 1'b0);     // invalid code leaves the config unchanged
        run_single(4'd15, 1'b1);
        test_back_pressure();
        test_random();

        $display("summary: %0d errors, %0d streams, %0d commands", errors,
                 stream_count, sent_count);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
design/video_reconf_pkg.sv
design/mode_cmd_queue.sv
design/reconf_rom.sv
design/pll_reconfig_ctrl.sv
design/video_reconf_top.sv
tb/tb_video_reconf.sv
